// ==== conv1d_assertions.sv ====
/*
 * conv1d MAC engine assertions
 * done handshake rules around the start pulse, bound into the engine
 */
`timescale 1ns/1ps

module conv1d_assertions (
  input logic clk,
  input logic arst_n,
  input logic start,
  input logic done
);

  // cycles spent busy since the last start
  logic [7:0] busy_cycles;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy_cycles <= '0;
    end else if (start || done) begin
      busy_cycles <= '0;
    end else begin
      busy_cycles <= busy_cycles + 8'd1;
    end
  end

  done_low_after_start: assert property (@(posedge clk) disable iff (!arst_n)
    start |=> !done) else $error("done still high in the cycle after start");

  done_held_until_start: assert property (@(posedge clk) disable iff (!arst_n)
    done && !start |=> done) else $error("done fell without a start");

  // the longest run is two cycles for each word pair of a full buffer
  done_within_limit: assert property (@(posedge clk) disable iff (!arst_n)
    !done |-> busy_cycles < 2 * conv1d_pkg::BUFFER_WORDS + 4)
    else $error("done did not return in time after start");

endmodule

bind conv1d_mac_engine conv1d_assertions u_conv1d_assertions (
  .clk    (clk),
  .arst_n (arst_n),
  .start  (start),
  .done   (done)
);

// ==== conv1d_cmd_decoder.sv ====
/*
 * conv1d command decoder
 * turns en/cmd strobes into configuration, buffer writes and start pulses,
 * and returns info, accumulator or done status on ret
 */
`timescale 1ns/1ps

module conv1d_cmd_decoder (
  input  logic clk,
  input  logic arst_n,
  input  logic en,
  input  conv1d_pkg::cmd_e cmd,
  input  logic [conv1d_pkg::WORD_W-1:0] inp0,
  input  logic [conv1d_pkg::WORD_W-1:0] inp1,
  input  logic signed [conv1d_pkg::WORD_W-1:0] acc,
  input  logic done,
  output logic [conv1d_pkg::WORD_W-1:0] ret,
  output conv1d_pkg::conv_cfg_t cfg,
  output conv1d_pkg::buf_write_t wr,
  output logic start
);

  logic input_we;
  logic filter_we;
  logic [conv1d_pkg::WADDR_W-1:0] wr_addr;
  logic [conv1d_pkg::WORD_W-1:0] wr_data;
  logic is_write;

  // the two write commands share one address and data register
  assign is_write = en && (cmd == conv1d_pkg::CMD_WRITE_INPUT ||
                           cmd == conv1d_pkg::CMD_WRITE_FILTER);

  // the write enables and start only live for one cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ret <= '0;
      cfg <= '0;
      input_we <= 1'b0;
      filter_we <= 1'b0;
      start <= 1'b0;
    end else begin
      input_we <= 1'b0;
      filter_we <= 1'b0;
      start <= 1'b0;
      if (en) begin
        case (cmd)
          conv1d_pkg::CMD_INFO:         ret <= conv1d_pkg::WORD_W'(conv1d_pkg::SUM_AT_ONCE);
          conv1d_pkg::CMD_WRITE_INPUT:  input_we <= 1'b1;
          conv1d_pkg::CMD_WRITE_FILTER: filter_we <= 1'b1;
          conv1d_pkg::CMD_SET_OFFSET:   cfg.input_offset <= inp1;
          conv1d_pkg::CMD_SET_DEPTH:    cfg.input_depth <= inp1;
          conv1d_pkg::CMD_START:        start <= 1'b1;
          conv1d_pkg::CMD_READ_ACC:     ret <= acc;
          conv1d_pkg::CMD_SET_START_X:  cfg.start_x <= inp1;
          conv1d_pkg::CMD_READ_DONE:    ret <= conv1d_pkg::WORD_W'(done);
          // unknown codes such as code 4 read back zero
          default:                      ret <= '0;
        endcase
      end
    end
  end

  // inp0 is a byte address while the buffers are word addressed
  always_ff @(posedge clk) begin
    if (is_write) begin
      wr_addr <= inp0[conv1d_pkg::BYTE_SEL_W +: conv1d_pkg::WADDR_W];
      wr_data <= inp1;
    end
  end

  assign wr.input_we = input_we;
  assign wr.filter_we = filter_we;
  assign wr.word_addr = wr_addr;
  assign wr.data.word = wr_data;

endmodule

// ==== conv1d_mac_engine.sv ====
/*
 * conv1d MAC engine
 * walks the kernel and the input ring two words per step and accumulates
 * eight filter x (input + offset) products into a signed 32-bit sum
 */
`timescale 1ns/1ps

module conv1d_mac_engine (
  input  logic clk,
  input  logic arst_n,
  input  logic start,
  input  conv1d_pkg::conv_cfg_t cfg,
  input  conv1d_pkg::buf_read_data_t rd_data,
  output conv1d_pkg::buf_read_req_t rd_req,
  output logic signed [conv1d_pkg::WORD_W-1:0] acc,
  output logic done
);

  // byte addresses into the filter and the input ring
  logic [conv1d_pkg::WORD_W-1:0] kernel_addr;
  logic [conv1d_pkg::WORD_W-1:0] input_addr;
  // low is the address cycle, high is the accumulate cycle
  logic acc_phase;

  logic [conv1d_pkg::WORD_W-1:0] span_bytes;
  logic [conv1d_pkg::WORD_W-1:0] ring_start;
  logic [conv1d_pkg::WORD_W-1:0] kernel_next;
  logic [conv1d_pkg::WORD_W-1:0] input_step;
  logic [conv1d_pkg::WORD_W-1:0] input_next;
  logic signed [conv1d_pkg::WORD_W-1:0] step_sum;

  // kernel and ring cover the same number of bytes, KERNEL_LENGTH rows of depth
  assign span_bytes = conv1d_pkg::KERNEL_LENGTH * cfg.input_depth;
  assign ring_start = (cfg.start_x % conv1d_pkg::KERNEL_LENGTH) * cfg.input_depth;

  assign kernel_next = kernel_addr + conv1d_pkg::SUM_AT_ONCE;
  assign input_step = input_addr + conv1d_pkg::SUM_AT_ONCE;
  // depth is a multiple of 8 so a step never straddles the wrap point
  assign input_next = (input_step >= span_bytes) ? input_step - span_bytes : input_step;

  assign rd_req.filter_word_addr = kernel_addr[conv1d_pkg::BYTE_SEL_W +: conv1d_pkg::WADDR_W];
  assign rd_req.input_word_addr = input_addr[conv1d_pkg::BYTE_SEL_W +: conv1d_pkg::WADDR_W];

  // eight lane products of the pair that came back from the buffers
  always_comb begin
    step_sum = '0;
    for (int w = 0; w < conv1d_pkg::WORDS_PER_STEP; w++) begin
      for (int l = 0; l < conv1d_pkg::LANES_PER_WORD; l++) begin
        step_sum += conv1d_pkg::WORD_W'(rd_data.filter_word[w].lane[l]) *
                    (conv1d_pkg::WORD_W'(rd_data.input_word[w].lane[l]) + cfg.input_offset);
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done <= 1'b1;
      acc <= '0;
      acc_phase <= 1'b0;
      kernel_addr <= '0;
      input_addr <= '0;
    end else if (start) begin
      // a start while busy simply restarts from the first step
      done <= 1'b0;
      acc <= '0;
      acc_phase <= 1'b0;
      kernel_addr <= '0;
      input_addr <= ring_start;
    end else if (!done) begin
      if (!acc_phase) begin
        // the addresses are on rd_req this cycle, data arrives next cycle
        acc_phase <= 1'b1;
      end else begin
        acc_phase <= 1'b0;
        acc <= acc + step_sum;
        kernel_addr <= kernel_next;
        input_addr <= input_next;
        if (kernel_next >= span_bytes) begin
          done <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== conv1d_operand_buffers.sv ====
/*
 * conv1d operand buffers
 * input ring memory and filter memory, one shared write port and a
 * registered read of an even/odd word pair from each memory
 */
`timescale 1ns/1ps

module conv1d_operand_buffers (
  input  logic clk,
  input  conv1d_pkg::buf_write_t wr,
  input  conv1d_pkg::buf_read_req_t rd_req,
  output conv1d_pkg::buf_read_data_t rd_data
);

  // index 0 is the input ring, index 1 the filter
  logic [1:0] we;
  logic [conv1d_pkg::WADDR_W-1:0] raddr [2];

  assign we[0] = wr.input_we;
  assign we[1] = wr.filter_we;
  assign raddr[0] = rd_req.input_word_addr;
  assign raddr[1] = rd_req.filter_word_addr;

  for (genvar m = 0; m < 2; m++) begin : g_mem
    conv1d_pkg::lane_word_u mem [conv1d_pkg::BUFFER_WORDS];
    conv1d_pkg::lane_word_u [conv1d_pkg::WORDS_PER_STEP-1:0] rword;
    logic [conv1d_pkg::WADDR_W-2:0] pair;

    // the low address bit is ignored, a step always reads a whole pair
    assign pair = raddr[m][conv1d_pkg::WADDR_W-1:1];

    always_ff @(posedge clk) begin
      if (we[m]) begin
        mem[wr.word_addr] <= wr.data;
      end
      rword[0] <= mem[{pair, 1'b0}];
      rword[1] <= mem[{pair, 1'b1}];
    end
  end

  assign rd_data.input_word = g_mem[0].rword;
  assign rd_data.filter_word = g_mem[1].rword;

endmodule

// ==== conv1d_pkg.sv ====
/*
 * conv1d accelerator shared definitions
 * sizes, command codes, the buffer word view and the structs passed
 * between the decoder, the operand buffers and the MAC engine
 */
package conv1d_pkg;

  // word and lane geometry
  localparam int WORD_W = 32;
  localparam int LANE_W = 8;
  localparam int LANES_PER_WORD = 4;
  localparam int BYTE_SEL_W = $clog2(LANES_PER_WORD);

  // kernel rows, which is also the number of rows held in the input ring
  localparam int KERNEL_LENGTH = 8;
  localparam int MAX_INPUT_CHANNELS = 32;

  // byte products summed per accumulate step, two buffer words
  localparam int SUM_AT_ONCE = 8;
  localparam int WORDS_PER_STEP = SUM_AT_ONCE / LANES_PER_WORD;

  localparam int BUFFER_WORDS = KERNEL_LENGTH * MAX_INPUT_CHANNELS / LANES_PER_WORD;
  localparam int WADDR_W = $clog2(BUFFER_WORDS);

  // host command codes, anything not listed reads back as zero
  typedef enum logic [6:0] {
    CMD_INFO         = 7'd0,
    CMD_WRITE_INPUT  = 7'd1,
    CMD_WRITE_FILTER = 7'd2,
    CMD_SET_OFFSET   = 7'd3,
    CMD_SET_DEPTH    = 7'd5,
    CMD_START        = 7'd6,
    CMD_READ_ACC     = 7'd7,
    CMD_SET_START_X  = 7'd8,
    CMD_READ_DONE    = 7'd9
  } cmd_e;

  typedef logic signed [LANE_W-1:0] lane_t;

  // the host writes whole words, the engine reads them as four signed bytes
  // with lane 0 in the low byte
  typedef union packed {
    logic [WORD_W-1:0] word;
    lane_t [LANES_PER_WORD-1:0] lane;
  } lane_word_u;

  typedef struct packed {
    logic signed [WORD_W-1:0] input_offset;
    logic [WORD_W-1:0] input_depth;
    logic [WORD_W-1:0] start_x;
  } conv_cfg_t;

  typedef struct packed {
    logic input_we;
    logic filter_we;
    logic [WADDR_W-1:0] word_addr;
    lane_word_u data;
  } buf_write_t;

  // both addresses point at the even word of a pair
  typedef struct packed {
    logic [WADDR_W-1:0] input_word_addr;
    logic [WADDR_W-1:0] filter_word_addr;
  } buf_read_req_t;

  typedef struct packed {
    lane_word_u [WORDS_PER_STEP-1:0] input_word;
    lane_word_u [WORDS_PER_STEP-1:0] filter_word;
  } buf_read_data_t;

endpackage

// ==== conv1d_top.sv ====
/*
 * conv1d accelerator top level
 * command decoder, operand buffers and MAC engine behind an en/cmd port
 */
`timescale 1ns/1ps

module conv1d_top (
  input  logic clk,
  input  logic arst_n,
  input  logic en,
  input  logic [6:0] cmd,
  input  logic [conv1d_pkg::WORD_W-1:0] inp0,
  input  logic [conv1d_pkg::WORD_W-1:0] inp1,
  output logic [conv1d_pkg::WORD_W-1:0] ret
);

  conv1d_pkg::conv_cfg_t cfg;
  conv1d_pkg::buf_write_t wr;
  conv1d_pkg::buf_read_req_t rd_req;
  conv1d_pkg::buf_read_data_t rd_data;
  logic start;
  logic done;
  logic signed [conv1d_pkg::WORD_W-1:0] acc;

  // raw 7-bit codes come in, the decoder works on the enum view
  conv1d_cmd_decoder u_cmd_decoder (
    .clk    (clk),
    .arst_n (arst_n),
    .en     (en),
    .cmd    (conv1d_pkg::cmd_e'(cmd)),
    .inp0   (inp0),
    .inp1   (inp1),
    .acc    (acc),
    .done   (done),
    .ret    (ret),
    .cfg    (cfg),
    .wr     (wr),
    .start  (start)
  );

  conv1d_operand_buffers u_operand_buffers (
    .clk     (clk),
    .wr      (wr),
    .rd_req  (rd_req),
    .rd_data (rd_data)
  );

  conv1d_mac_engine u_mac_engine (
    .clk     (clk),
    .arst_n  (arst_n),
    .start   (start),
    .cfg     (cfg),
    .rd_data (rd_data),
    .rd_req  (rd_req),
    .acc     (acc),
    .done    (done)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# compile and run the conv1d testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_conv1d -o sim_conv1d; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/sim_conv1d)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
  exit 0
fi
exit 1

// ==== tb_conv1d.sv ====
/*
 * conv1d accelerator testbench
 * fills both buffers with xorshift data, runs convolutions through the
 * en/cmd port and compares every checked ret read with a reference model
 */
`timescale 1ns/1ps

module tb_conv1d;

  logic clk;
  logic arst_n;
  logic en;
  logic [6:0] cmd;
  logic [31:0] inp0;
  logic [31:0] inp1;
  logic [31:0] ret;

  // a checked read is announced together with its command
  logic chk_valid;
  logic [31:0] chk_exp;
  logic [31:0] exp_now;
  logic [31:0] rng_state;

  // shadow copies of the two buffers hold one signed byte per entry
  logic signed [7:0] input_bytes [conv1d_pkg::BUFFER_WORDS * conv1d_pkg::LANES_PER_WORD];
  logic signed [7:0] filter_bytes [conv1d_pkg::BUFFER_WORDS * conv1d_pkg::LANES_PER_WORD];

  conv1d_top u_conv1d_top (
    .clk    (clk),
    .arst_n (arst_n),
    .en     (en),
    .cmd    (cmd),
    .inp0   (inp0),
    .inp1   (inp1),
    .ret    (ret)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // sum over all kernel bytes of filter x (ring input + offset)
  function automatic logic [31:0] conv_ref(input int depth, input int start_x, input int offset);
    int span;
    int pos;
    int i;
    int sum;
    span = conv1d_pkg::KERNEL_LENGTH * depth;
    sum = 0;
    for (i = 0; i < span; i++) begin
      // the ring starts at row start_x and wraps after KERNEL_LENGTH rows
      pos = (start_x * depth + i) % span;
      sum += int'(filter_bytes[i]) * (int'(input_bytes[pos]) + offset);
    end
    return 32'(sum);
  endfunction

  // one command takes two cycles and en is high for exactly one rising edge
  task automatic send_cmd(input logic [6:0] code, input logic [31:0] a, input logic [31:0] b,
                          input logic check, input logic [31:0] expected);
    @(negedge clk);
    en = 1'b1;
    cmd = code;
    inp0 = a;
    inp1 = b;
    chk_valid = check;
    chk_exp = expected;
    @(negedge clk);
    en = 1'b0;
    chk_valid = 1'b0;
  endtask

  task automatic read_expect(input logic [6:0] code, input logic [31:0] expected);
    send_cmd(code, 32'd0, 32'd0, 1'b1, expected);
  endtask

  task automatic fill_buffers();
    int w;
    int b;
    logic [31:0] in_word;
    logic [31:0] flt_word;
    for (w = 0; w < conv1d_pkg::BUFFER_WORDS; w++) begin
      rng_state = xorshift32(rng_state);
      in_word = rng_state;
      rng_state = xorshift32(rng_state);
      flt_word = rng_state;
      send_cmd(conv1d_pkg::CMD_WRITE_INPUT, 32'(w * 4), in_word, 1'b0, 32'd0);
      send_cmd(conv1d_pkg::CMD_WRITE_FILTER, 32'(w * 4), flt_word, 1'b0, 32'd0);
      // lane 0 sits in the low byte of each word
      for (b = 0; b < 4; b++) begin
        input_bytes[w * 4 + b] = in_word[b * 8 +: 8];
        filter_bytes[w * 4 + b] = flt_word[b * 8 +: 8];
      end
    end
  endtask

  task automatic set_config(input int depth, input int start_x, input int offset);
    send_cmd(conv1d_pkg::CMD_SET_DEPTH, 32'd0, 32'(depth), 1'b0, 32'd0);
    send_cmd(conv1d_pkg::CMD_SET_OFFSET, 32'd0, 32'(offset), 1'b0, 32'd0);
    send_cmd(conv1d_pkg::CMD_SET_START_X, 32'd0, 32'(start_x), 1'b0, 32'd0);
  endtask

  // polls the done flag for at most 400 cycles
  task automatic wait_for_done();
    int cycles;
    logic finished;
    cycles = 0;
    finished = 1'b0;
    while (!finished && cycles < 400) begin
      send_cmd(conv1d_pkg::CMD_READ_DONE, 32'd0, 32'd0, 1'b0, 32'd0);
      cycles += 2;
      finished = (ret == 32'd1);
    end
    assert (finished) else begin
      $display("Timeout: the done flag did not rise within 400 cycles of polling");
      $display("Finished with errors");
      $fatal(1, "done poll timeout");
    end
  endtask

  task automatic run_conv(input int depth, input int start_x, input int offset);
    set_config(depth, start_x, offset);
    send_cmd(conv1d_pkg::CMD_START, 32'd0, 32'd0, 1'b0, 32'd0);
    wait_for_done();
    read_expect(conv1d_pkg::CMD_READ_ACC, conv_ref(depth, start_x, offset));
  endtask

  // ret is updated at the rising edge of the command and checked at the
  // following falling edge, where it is stable
  always begin
    @(posedge clk);
    if (chk_valid) begin
      exp_now = chk_exp;
      @(negedge clk);
      assert (ret === exp_now) else begin
        $display("Error ret expected %h got %h", exp_now, ret);
        $display("Finished with errors");
        $fatal(1, "ret mismatch");
      end
    end
  end

  initial begin
    int offset;
    arst_n = 1'b0;
    en = 1'b0;
    cmd = 7'd0;
    inp0 = 32'd0;
    inp1 = 32'd0;
    chk_valid = 1'b0;
    chk_exp = 32'd0;
    exp_now = 32'd0;
    rng_state = 32'h73dc_67e5;
    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // reset state of done and the accumulator
    read_expect(conv1d_pkg::CMD_READ_DONE, 32'd1);
    read_expect(conv1d_pkg::CMD_READ_ACC, 32'd0);

    // info returns the products per step and unknown codes return zero
    read_expect(conv1d_pkg::CMD_INFO, 32'd8);
    read_expect(7'd4, 32'd0);
    read_expect(conv1d_pkg::CMD_INFO, 32'd8);
    read_expect(7'd20, 32'd0);

    fill_buffers();
    run_conv(8, 0, 0);

    // full depth with a ring start in the middle and a negative offset
    fill_buffers();
    rng_state = xorshift32(rng_state);
    offset = -1 - int'(rng_state[6:0]);
    run_conv(32, 5, offset);

    // a fresh start clears acc and done reads low straight after it
    rng_state = xorshift32(rng_state);
    offset = -1 - int'(rng_state[6:0]);
    set_config(32, 2, offset);
    send_cmd(conv1d_pkg::CMD_START, 32'd0, 32'd0, 1'b0, 32'd0);
    read_expect(conv1d_pkg::CMD_READ_DONE, 32'd0);
    wait_for_done();
    read_expect(conv1d_pkg::CMD_READ_ACC, conv_ref(32, 2, offset));

    // on a restart while busy only the second start counts
    set_config(32, 3, 0);
    send_cmd(conv1d_pkg::CMD_START, 32'd0, 32'd0, 1'b0, 32'd0);
    read_expect(conv1d_pkg::CMD_READ_DONE, 32'd0);
    set_config(32, 7, 17);
    send_cmd(conv1d_pkg::CMD_START, 32'd0, 32'd0, 1'b0, 32'd0);
    read_expect(conv1d_pkg::CMD_READ_DONE, 32'd0);
    wait_for_done();
    read_expect(conv1d_pkg::CMD_READ_ACC, conv_ref(32, 7, 17));

    // the last read is compared at the falling edge where read_expect returns
    @(posedge clk);

    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== vlog.f ====
conv1d_pkg.sv
conv1d_cmd_decoder.sv
conv1d_operand_buffers.sv
conv1d_mac_engine.sv
conv1d_top.sv
conv1d_assertions.sv
tb_conv1d.sv
